// ==== src.f ====
game_pkg.sv
tick_timer.sv
player_fsm.sv
spawn_lfsr.sv
enemy_grid.sv
game_top.sv
tb_game.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the game state testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f src.f --top-module tb_game -o sim_game

./obj_dir/sim_game > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"

// ==== tb_game.sv ====
`timescale 1ns/10ps

module tb_game;

    //////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////

    logic                        blockieee_clock;
    logic                        rst;
    logic [7:0]                  stick_y;
    logic [3:0]                  player_pos;
    logic                        dead;
    logic [game_pkg::GRID_W-1:0] grid_cells;

    // Stick classes with separate dead-zone edges
    typedef enum int {
        CL_UP,
        CL_DOWN,
        CL_CENTER,
        CL_UP_EDGE,
        CL_DOWN_EDGE,
        CL_CENTER_LO,
        CL_CENTER_HI
    } stick_class_t;

    // One table row holds stick class, hold in player ticks and expected result
    typedef struct packed {
        stick_class_t cls;
        int           hold;
        logic [3:0]   exp_pos;
        logic         exp_dead;
    } step_t;

    localparam int NUM_STEPS = 10;
    step_t steps [NUM_STEPS];

    // Model move direction
    typedef enum logic [1:0] {
        MV_STEADY,
        MV_UP,
        MV_DOWN
    } move_t;

    // Reference model of player, LFSR and grid
    int          cyc;
    int          enemy_ticks;
    logic [15:0] m_lfsr;
    logic [2:0]  m_grid [game_pkg::ROWS][game_pkg::COLS];
    move_t       m_move;
    logic [3:0]  m_pos;
    logic        m_dead;

    // Stimulus generator state
    logic [31:0] lcg_state;

    // Grid snapshots for freeze and recovery checks
    logic [game_pkg::GRID_W-1:0] first_grid;
    logic                        first_saved;
    logic [game_pkg::GRID_W-1:0] frozen_grid;

    int player_errs;
    int grid_errs;
    int step_errs;

    game_top dut (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .stick_y         (stick_y),
        .player_pos      (player_pos),
        .dead            (dead),
        .grid_cells      (grid_cells)
    );

    // 40 ns clock
    initial begin
        blockieee_clock = 1'b0;
        forever begin
            #20 blockieee_clock = ~blockieee_clock;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Up above 148 and down below 108 with the dead zone between
    function automatic logic [7:0] stick_value(input stick_class_t cls);
        logic [31:0] r;
        int          v;
        r = lcg_next() >> 16;
        case (cls)
            CL_UP:        v = 149 + int'(r % 32'd107);
            CL_DOWN:      v = int'(r % 32'd108);
            CL_CENTER:    v = 108 + int'(r % 32'd41);
            CL_UP_EDGE:   v = 149;
            CL_DOWN_EDGE: v = 107;
            CL_CENTER_LO: v = 108;
            default:      v = 148;
        endcase
        return 8'(v);
    endfunction

    // Positions worked out by hand from the move rules
    // Dead-zone edges sit where a wrong move would leave the clamp
    // Breach lands on player tick 28 at the first drain tick
    task automatic fill_step_table();
        steps[0] = '{CL_UP,        3, 4'd3,  1'b0};
        steps[1] = '{CL_UP,        4, 4'd0,  1'b0};
        steps[2] = '{CL_CENTER_LO, 2, 4'd0,  1'b0};
        steps[3] = '{CL_DOWN_EDGE, 3, 4'd2,  1'b0};
        steps[4] = '{CL_DOWN,      9, 4'd10, 1'b0};
        steps[5] = '{CL_CENTER_HI, 2, 4'd10, 1'b0};
        steps[6] = '{CL_UP_EDGE,   2, 4'd9,  1'b0};
        steps[7] = '{CL_CENTER,    2, 4'd8,  1'b0};
        steps[8] = '{CL_DOWN,      3, 4'd5,  1'b1};
        steps[9] = '{CL_UP,        4, 4'd5,  1'b1};
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    task automatic reset_model();
        cyc         = 0;
        enemy_ticks = 0;
        m_lfsr      = 16'hACE1;
        m_move      = MV_STEADY;
        m_pos       = 4'd5;
        m_dead      = 1'b0;
        for (int r = 0; r < game_pkg::ROWS; r++) begin
            for (int c = 0; c < game_pkg::COLS; c++) begin
                m_grid[r][c] = 3'd0;
            end
        end
    endtask

    // One clock edge already counted in cyc
    task automatic model_edge();
        logic       p_tick;
        logic       e_tick;
        logic       filling;
        logic       busy;
        logic [2:0] raw;
        logic [2:0] ins;
        p_tick  = (cyc % game_pkg::PLAYER_TICK_CYCLES == 0);
        e_tick  = (cyc % game_pkg::ENEMY_TICK_CYCLES == 0);
        filling = 1'b0;
        busy    = 1'b0;
        if (e_tick) begin
            enemy_ticks++;
            // Six fill ticks then six drain ticks in turn
            filling = (((enemy_ticks - 1) / game_pkg::COLS) % 2 == 0);
        end
        for (int r = 0; r < game_pkg::ROWS; r++) begin
            busy = busy | (m_grid[r][0] != 3'd0);
        end
        if (e_tick && !m_dead && busy) begin
            // Game over wins over any move on this edge
            m_dead = 1'b1;
            m_pos  = 4'd5;
        end else begin
            if (e_tick && !m_dead) begin
                for (int r = 0; r < game_pkg::ROWS; r++) begin
                    raw = m_lfsr[3*r +: 3];
                    ins = (filling && raw != 3'd7) ? raw : 3'd0;
                    for (int c = 0; c < game_pkg::COLS - 1; c++) begin
                        m_grid[r][c] = m_grid[r][c+1];
                    end
                    m_grid[r][game_pkg::COLS-1] = ins;
                end
                // LFSR steps after its colours were used
                if (filling) begin
                    m_lfsr = {m_lfsr[14:0], m_lfsr[15] ^ m_lfsr[13] ^ m_lfsr[12] ^ m_lfsr[10]};
                end
            end
            if (p_tick && !m_dead) begin
                // Old direction moves and the new one is loaded
                if (m_move == MV_UP && m_pos != 4'd0) begin
                    m_pos = m_pos - 4'd1;
                end else if (m_move == MV_DOWN && m_pos < 4'd10) begin
                    m_pos = m_pos + 4'd1;
                end
                if (stick_y > 8'd148) begin
                    m_move = MV_UP;
                end else if (stick_y < 8'd108) begin
                    m_move = MV_DOWN;
                end else begin
                    m_move = MV_STEADY;
                end
            end
        end
    endtask

    function automatic logic [game_pkg::GRID_W-1:0] model_cells();
        logic [game_pkg::GRID_W-1:0] flat;
        flat = '0;
        for (int r = 0; r < game_pkg::ROWS; r++) begin
            for (int c = 0; c < game_pkg::COLS; c++) begin
                flat[(r*game_pkg::COLS + c)*3 +: 3] = m_grid[r][c];
            end
        end
        return flat;
    endfunction

    //////////////////////////////////////////////////
    // Checks and cycle stepping
    //////////////////////////////////////////////////

    task automatic report_counts();
        $display("Errors: player %0d, grid %0d, steps %0d", player_errs, grid_errs, step_errs);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        report_counts();
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic compare_outputs();
        assert (player_pos == m_pos && dead == m_dead) else begin
            player_errs++;
            $display("ERR %0t: player_pos %0d dead %0b, model %0d %0b",
                     $time, player_pos, dead, m_pos, m_dead);
        end
        // Grid only changes on enemy ticks
        if (cyc % game_pkg::ENEMY_TICK_CYCLES == 0) begin
            assert (grid_cells == model_cells()) else begin
                grid_errs++;
                $display("ERR %0t: grid_cells %h after enemy tick %0d, model %h",
                         $time, grid_cells, enemy_ticks, model_cells());
            end
        end
    endtask

    // Rising edge updates the model and falling edge checks the DUT
    task automatic run_cycle();
        @(posedge blockieee_clock);
        cyc++;
        model_edge();
        @(negedge blockieee_clock);
        compare_outputs();
        if (!first_saved && enemy_ticks == 1) begin
            first_grid  = grid_cells;
            first_saved = 1'b1;
        end
    endtask

    task automatic hold_ticks(input int n);
        int seen;
        int guard;
        seen  = 0;
        guard = 0;
        while (seen < n && guard < n * game_pkg::PLAYER_TICK_CYCLES + 8) begin
            run_cycle();
            guard++;
            if (cyc % game_pkg::PLAYER_TICK_CYCLES == 0) begin
                seen++;
            end
        end
        if (seen < n) begin
            abort_on_timeout("player ticks");
        end
    endtask

    task automatic wait_enemy_ticks(input int n);
        int seen;
        int guard;
        seen  = 0;
        guard = 0;
        while (seen < n && guard < (n + 1) * game_pkg::ENEMY_TICK_CYCLES) begin
            run_cycle();
            guard++;
            if (cyc % game_pkg::ENEMY_TICK_CYCLES == 0) begin
                seen++;
            end
        end
        if (seen < n) begin
            abort_on_timeout("enemy ticks");
        end
    endtask

    // Eight cycles of reset released on a falling edge
    task automatic apply_reset();
        @(negedge blockieee_clock);
        rst = 1'b1;
        for (int n = 0; n < 8; n++) begin
            @(posedge blockieee_clock);
        end
        @(negedge blockieee_clock);
        rst = 1'b0;
        reset_model();
    endtask

    task automatic check_reset_state();
        assert (player_pos == 4'd5 && dead == 1'b0) else begin
            player_errs++;
            $display("ERR %0t: after reset player_pos %0d dead %0b", $time, player_pos, dead);
        end
        assert (grid_cells == '0) else begin
            grid_errs++;
            $display("ERR %0t: after reset grid_cells %h", $time, grid_cells);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        stick_y     = 8'd128;
        lcg_state   = 32'hda38;
        first_saved = 1'b0;
        first_grid  = '0;
        frozen_grid = '0;
        player_errs = 0;
        grid_errs   = 0;
        step_errs   = 0;
        reset_model();
        fill_step_table();

        apply_reset();
        check_reset_state();

        // Movement, clamping and dead zone with game over midway
        for (int i = 0; i < NUM_STEPS; i++) begin
            stick_y = stick_value(steps[i].cls);
            hold_ticks(steps[i].hold);
            assert (player_pos == steps[i].exp_pos && dead == steps[i].exp_dead) else begin
                step_errs++;
                $display("ERR %0t: step %0d player_pos %0d dead %0b, expected %0d %0b",
                         $time, i, player_pos, dead, steps[i].exp_pos, steps[i].exp_dead);
            end
        end

        // Frozen grid and player after game over
        frozen_grid = grid_cells;
        stick_y = stick_value(CL_UP);
        wait_enemy_ticks(2);
        assert (grid_cells == frozen_grid && player_pos == 4'd5 && dead) else begin
            step_errs++;
            $display("ERR %0t: grid or player moved after game over", $time);
        end

        // Second reset replays the spawn sequence from the seed
        apply_reset();
        check_reset_state();
        stick_y = stick_value(CL_CENTER);
        wait_enemy_ticks(1);
        assert (grid_cells == first_grid) else begin
            grid_errs++;
            $display("ERR %0t: first spawn after reset %h, first run %h",
                     $time, grid_cells, first_grid);
        end
        wait_enemy_ticks(game_pkg::COLS - 1);

        report_counts();
        if (player_errs + grid_errs + step_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== game_top.sv ====
`timescale 1ns/10ps

module game_top (
    input  logic                        blockieee_clock,
    input  logic                        rst,
    input  logic [7:0]                  stick_y,
    output logic [3:0]                  player_pos,
    output logic                        dead,
    output logic [game_pkg::GRID_W-1:0] grid_cells
);

    // Tick enables and wave phase
    logic player_tick;
    logic enemy_tick;
    logic wave_filling;

    // Grid to player machine and LFSR
    logic breach;
    logic advance;

    // Spawn colours for the right edge
    logic [game_pkg::SPAWN_W-1:0] spawn_colors;

    //////////////////////////////////////////////////
    // Timing
    //////////////////////////////////////////////////

    tick_timer u_tick_timer (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .player_tick     (player_tick),
        .enemy_tick      (enemy_tick),
        .wave_filling    (wave_filling)
    );

    //////////////////////////////////////////////////
    // Player and enemies
    //////////////////////////////////////////////////

    // Dead is also the top-level game-over flag
    player_fsm u_player_fsm (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .player_tick     (player_tick),
        .stick_y         (stick_y),
        .breach          (breach),
        .player_pos      (player_pos),
        .dead            (dead)
    );

    spawn_lfsr u_spawn_lfsr (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .advance         (advance),
        .spawn_colors    (spawn_colors)
    );

    // Grid freezes once dead is high
    enemy_grid u_enemy_grid (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .enemy_tick      (enemy_tick),
        .wave_filling    (wave_filling),
        .dead            (dead),
        .spawn_colors    (spawn_colors),
        .advance         (advance),
        .breach          (breach),
        .grid_cells      (grid_cells)
    );

endmodule

// ==== enemy_grid.sv ====
`timescale 1ns/10ps

module enemy_grid (
    input  logic                         blockieee_clock,
    input  logic                         rst,
    input  logic                         enemy_tick,
    input  logic                         wave_filling,
    input  logic                         dead,
    input  logic [game_pkg::SPAWN_W-1:0] spawn_colors,
    output logic                         advance,
    output logic                         breach,
    output logic [game_pkg::GRID_W-1:0]  grid_cells
);

    // Cell storage, column 0 is the player side
    game_pkg::enemy_color_t cells [game_pkg::ROWS][game_pkg::COLS];

    // Raw spawn colour per row
    logic [game_pkg::COLOR_W-1:0] spawn_raw [game_pkg::ROWS];

    // Column entering at the right edge
    game_pkg::enemy_color_t in_col [game_pkg::ROWS];

    // Any enemy already in column 0
    logic col0_busy;

    // Grid moves this cycle
    logic shift_en;

    //////////////////////////////////////////////////
    // Spawn column
    //////////////////////////////////////////////////

    // Slice one colour per row
    for (genvar r = 0; r < game_pkg::ROWS; r++) begin : g_spawn
        assign spawn_raw[r] = spawn_colors[r*game_pkg::COLOR_W +: game_pkg::COLOR_W];
    end

    // Raw 7 has no colour, shows as empty
    // Drain phase feeds empty cells
    always_comb begin
        for (int r = 0; r < game_pkg::ROWS; r++) begin
            if (!wave_filling || spawn_raw[r] == '1) begin
                in_col[r] = game_pkg::CLR_EMPTY;
            end else begin
                in_col[r] = game_pkg::enemy_color_t'(spawn_raw[r]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Breach check and shift control
    //////////////////////////////////////////////////

    always_comb begin
        col0_busy = 1'b0;
        for (int r = 0; r < game_pkg::ROWS; r++) begin
            col0_busy = col0_busy | (cells[r][0] != game_pkg::CLR_EMPTY);
        end
    end

    // Occupied home column ends the game instead of shifting
    assign breach   = enemy_tick && !dead && col0_busy;
    assign shift_en = enemy_tick && !dead && !col0_busy;

    // Step the LFSR only when its colours were taken
    assign advance  = shift_en && wave_filling;

    //////////////////////////////////////////////////
    // Cell registers
    //////////////////////////////////////////////////

    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            for (int r = 0; r < game_pkg::ROWS; r++) begin
                for (int c = 0; c < game_pkg::COLS; c++) begin
                    cells[r][c] <= game_pkg::CLR_EMPTY;
                end
            end
        end else if (shift_en) begin
            for (int r = 0; r < game_pkg::ROWS; r++) begin
                // Every column takes its right neighbour
                for (int c = 0; c < game_pkg::COLS - 1; c++) begin
                    cells[r][c] <= cells[r][c+1];
                end
                cells[r][game_pkg::COLS-1] <= in_col[r];
            end
        end
    end

    //////////////////////////////////////////////////
    // Flattened output
    //////////////////////////////////////////////////

    // Row-major, row 0 column 0 in the low bits
    for (genvar r = 0; r < game_pkg::ROWS; r++) begin : g_row
        for (genvar c = 0; c < game_pkg::COLS; c++) begin : g_col
            assign grid_cells[(r*game_pkg::COLS + c)*game_pkg::COLOR_W +: game_pkg::COLOR_W] =
                cells[r][c];
        end
    end

endmodule

// ==== spawn_lfsr.sv ====
`timescale 1ns/10ps

module spawn_lfsr (
    input  logic                         blockieee_clock,
    input  logic                         rst,
    input  logic                         advance,
    output logic [game_pkg::SPAWN_W-1:0] spawn_colors
);

    // Fibonacci shift register
    logic [15:0] lfsr;

    // Taps 16, 14, 13, 11 in one-based terms
    logic feedback;

    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    //////////////////////////////////////////////////
    // Shift on advance
    //////////////////////////////////////////////////

    // Grid samples the value before this step
    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            lfsr <= game_pkg::LFSR_SEED;
        end else if (advance) begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    // Low bits give one colour per row
    // Row r sits at bits 3r+2 down to 3r
    assign spawn_colors = lfsr[game_pkg::SPAWN_W-1:0];

endmodule

// ==== player_fsm.sv ====
`timescale 1ns/10ps

module player_fsm (
    input  logic                blockieee_clock,
    input  logic                rst,
    input  logic                player_tick,
    input  logic [7:0]          stick_y,
    input  logic                breach,
    output game_pkg::pos_t      player_pos,
    output logic                dead
);

    // Current state and the state the stick asks for
    game_pkg::player_state_t state;
    game_pkg::player_state_t stick_state;

    // Position after one move in the current state
    game_pkg::pos_t next_pos;

    //////////////////////////////////////////////////
    // Stick decode
    //////////////////////////////////////////////////

    // Dead zone around the rest value
    // Pushing the stick up gives a larger value
    always_comb begin
        if (int'(stick_y) > game_pkg::STICK_CENTER + game_pkg::STICK_TOL) begin
            stick_state = game_pkg::ST_UP;
        end else if (int'(stick_y) < game_pkg::STICK_CENTER - game_pkg::STICK_TOL) begin
            stick_state = game_pkg::ST_DOWN;
        end else begin
            stick_state = game_pkg::ST_STEADY;
        end
    end

    //////////////////////////////////////////////////
    // Move with clamping
    //////////////////////////////////////////////////

    // Move follows the state held before the tick
    always_comb begin
        next_pos = player_pos;
        case (state)
            game_pkg::ST_UP: begin
                // Top row is 0
                if (player_pos != '0) begin
                    next_pos = player_pos - 1'b1;
                end
            end
            game_pkg::ST_DOWN: begin
                // Stop at the bottom row
                if (player_pos < game_pkg::POS_MAX) begin
                    next_pos = player_pos + 1'b1;
                end
            end
            default: begin
                next_pos = player_pos;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // State and position registers
    //////////////////////////////////////////////////

    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            state      <= game_pkg::ST_STEADY;
            player_pos <= game_pkg::POS_HOME;
        end else if (breach) begin
            // Game over, back home and wait for reset
            state      <= game_pkg::ST_DEAD;
            player_pos <= game_pkg::POS_HOME;
        end else if (player_tick && state != game_pkg::ST_DEAD) begin
            // Stick sampled now moves the player on the next tick
            state      <= stick_state;
            player_pos <= next_pos;
        end
    end

    // Dead is just the state decoded
    assign dead = (state == game_pkg::ST_DEAD);

endmodule

// ==== tick_timer.sv ====
`timescale 1ns/10ps

module tick_timer (
    input  logic blockieee_clock,
    input  logic rst,
    output logic player_tick,
    output logic enemy_tick,
    output logic wave_filling
);

    // Free-running cycle counters
    logic [$clog2(game_pkg::PLAYER_TICK_CYCLES)-1:0] player_cnt;
    logic [$clog2(game_pkg::ENEMY_TICK_CYCLES)-1:0]  enemy_cnt;

    // Enemy ticks seen in the current wave phase
    logic [2:0] phase_cnt;

    //////////////////////////////////////////////////
    // Tick pulses
    //////////////////////////////////////////////////

    // Pulse on the last count of each period
    // Consumers act on the edge that ends this cycle
    assign player_tick = (player_cnt == game_pkg::PLAYER_TICK_CYCLES - 1);
    assign enemy_tick  = (enemy_cnt == game_pkg::ENEMY_TICK_CYCLES - 1);

    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            player_cnt <= '0;
        end else if (player_tick) begin
            player_cnt <= '0;
        end else begin
            player_cnt <= player_cnt + 1'b1;
        end
    end

    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            enemy_cnt <= '0;
        end else if (enemy_tick) begin
            enemy_cnt <= '0;
        end else begin
            enemy_cnt <= enemy_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Wave phase
    //////////////////////////////////////////////////

    // One phase lasts as many ticks as the grid is wide
    // Starts in fill phase
    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            phase_cnt    <= '0;
            wave_filling <= 1'b1;
        end else if (enemy_tick) begin
            if (phase_cnt == game_pkg::COLS - 1) begin
                phase_cnt    <= '0;
                wave_filling <= ~wave_filling;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== game_pkg.sv ====
package game_pkg;

    //////////////////////////////////////////////////
    // Playfield geometry
    //////////////////////////////////////////////////

    // Enemy rows and columns
    localparam int ROWS = 5;
    localparam int COLS = 6;

    // Bits per enemy colour cell
    localparam int COLOR_W = 3;

    // One spawn colour per row, packed row 0 lowest
    localparam int SPAWN_W = ROWS * COLOR_W;

    // Flattened grid, row-major
    localparam int GRID_W = ROWS * COLS * COLOR_W;

    // Player row, 0 is the top row
    typedef logic [3:0] pos_t;

    // Lowest row the player can reach
    localparam pos_t POS_MAX = 4'd10;
    // Row after reset or death
    localparam pos_t POS_HOME = 4'd5;

    //////////////////////////////////////////////////
    // Stick and timing
    //////////////////////////////////////////////////

    // Stick rest value and dead-zone half width
    localparam int STICK_CENTER = 128;
    localparam int STICK_TOL = 20;

    // Clock cycles per tick
    localparam int PLAYER_TICK_CYCLES = 4;
    localparam int ENEMY_TICK_CYCLES = 16;

    // Spawn LFSR start value, never all zero
    localparam logic [15:0] LFSR_SEED = 16'hACE1;

    // Player machine states
    typedef enum logic [1:0] {
        ST_STEADY = 2'd0,
        ST_UP     = 2'd1,
        ST_DOWN   = 2'd2,
        ST_DEAD   = 2'd3
    } player_state_t;

    // Enemy colours, raw value 7 unused
    typedef enum logic [COLOR_W-1:0] {
        CLR_EMPTY  = 3'd0,
        CLR_PURPLE = 3'd1,
        CLR_ORANGE = 3'd2,
        CLR_YELLOW = 3'd3,
        CLR_BLUE   = 3'd4,
        CLR_RED    = 3'd5,
        CLR_GREEN  = 3'd6
    } enemy_color_t;

endpackage
